// ==== hw/otp_svc_macros.svh ====
// ----------------------------------------
// OTP service block parameters
// Array geometry and the life-cycle reset
// hold length shared by all RTL files
// ----------------------------------------

`ifndef OTP_SVC_MACROS_SVH
`define OTP_SVC_MACROS_SVH

// ----------------------------------------
// Array geometry
// ----------------------------------------

// Number of identical partitions in the array
`define OTP_NUM_PART 7

// Words per partition, the last one holds the digest
`define OTP_PART_WORDS 4

// Width of one fuse word in bits
`define OTP_WORD_W 16

// ----------------------------------------
// Life-cycle reset
// ----------------------------------------

// Counter value at which the held reset is let go
// Counting from 0 this keeps the reset asserted for 11 cycles
`define OTP_RST_HOLD 10

`endif

// ==== hw/otp_cmd_pkg.sv ====
// ----------------------------------------
// OTP service command definitions
// Opcodes and the two views of the
// 16-bit command word
// ----------------------------------------

package otp_cmd_pkg;

  // Opcode sits in the top nibble of every command word
  typedef enum logic [3:0] {
    NOP           = 4'h0,
    FAULT_CORR    = 4'h1,
    FAULT_UNCORR  = 4'h2,
    FAULT_RELEASE = 4'h3,
    LC_RESET      = 4'h4,
    CLK_SEL       = 4'h5,
    ESC_SET       = 4'h6,
    ESC_CLR       = 4'h7
  } otp_opcode_e;

  // Clock selection view, frequency given in MHz
  typedef struct packed {
    otp_opcode_e opcode;
    logic [11:0] mhz;
  } otp_cmd_clk_t;

  // Escalation view, only the lowest bit picks the line
  typedef struct packed {
    otp_opcode_e opcode;
    logic [10:0] rsvd;
    logic        esc_line;
  } otp_cmd_esc_t;

  // Both views overlay the same 16 bits so the opcode lines up
  typedef union packed {
    otp_cmd_clk_t clk_view;
    otp_cmd_esc_t esc_view;
  } otp_cmd_u;

endpackage

// ==== hw/otp_part_pkg.sv ====
// ----------------------------------------
// OTP partition definitions
// Fault kinds and partition/word indices
// ----------------------------------------

package otp_part_pkg;

  // Kind of fault overlaid on word 0 of a locked partition
  typedef enum logic {
    CORRECTABLE   = 1'b0,
    UNCORRECTABLE = 1'b1
  } otp_fault_e;

  // Selects one of the seven partitions
  typedef logic [2:0] otp_part_idx_t;

  // Selects one of the four words inside a partition
  typedef logic [1:0] otp_word_idx_t;

endpackage

// ==== hw/otp_part_if.sv ====
// ----------------------------------------
// OTP partition control interface
// Programming and fault control from the
// decoder to one partition slice
// ----------------------------------------

`timescale 1ns/10ps

`include "otp_svc_macros.svh"

interface otp_part_if;
  import otp_part_pkg::*;

  // Word programming, a single-cycle strobe with its target and data
  logic                   prog_we;
  otp_word_idx_t          prog_word;
  logic [`OTP_WORD_W-1:0] prog_data;

  // Fault control, strobes shared by every slice
  logic                   inject;
  otp_fault_e             inject_kind;
  logic                   fault_release;

  modport ctrl (
    output prog_we, prog_word, prog_data, inject, inject_kind, fault_release
  );

  modport part (
    input prog_we, prog_word, prog_data, inject, inject_kind, fault_release
  );

endinterface

// ==== hw/otp_svc_decoder.sv ====
// ----------------------------------------
// OTP service command decoder
// Routes programming writes and fault
// strobes to the slices and holds the
// life-cycle reset, clock and escalation
// ----------------------------------------

`timescale 1ns/10ps

`include "otp_svc_macros.svh"

module otp_svc_decoder (
  input  logic                   clk,
  input  logic                   cptra_rst_b,
  input  logic                   cmd_valid_i,
  input  otp_cmd_pkg::otp_cmd_u  cmd_i,
  input  logic                   prog_we_i,
  input  logic [4:0]             prog_addr_i,
  input  logic [`OTP_WORD_W-1:0] prog_data_i,
  input  logic                   clk_byp_ack_i,
  output logic                   lc_rst_b_o,
  output logic [11:0]            clk_sel_o,
  output logic                   ext_clk_req_o,
  output logic                   clk_switch_o,
  output logic [1:0]             esc_o,
  otp_part_if.ctrl               part_o [`OTP_NUM_PART]
);
  import otp_cmd_pkg::*;
  import otp_part_pkg::*;

  localparam logic [11:0] CLK_RST_MHZ = 12'd1000;

  otp_opcode_e   cmd_op;
  otp_part_idx_t prog_part;
  otp_word_idx_t prog_word;
  logic          fault_cmd;
  logic          release_cmd;

  logic          fault_active_q;
  logic          inject_q;
  logic          release_q;
  otp_fault_e    inject_kind_q;

  logic          rst_active_q;
  logic [3:0]    rst_cnt_q;
  logic [11:0]   clk_sel_q;
  logic          ext_clk_req_q;
  logic [1:0]    esc_q;

  // Opcode is at the same place in both views
  assign cmd_op      = cmd_i.clk_view.opcode;
  assign fault_cmd   = cmd_valid_i && (cmd_op == FAULT_CORR || cmd_op == FAULT_UNCORR);
  assign release_cmd = cmd_valid_i && (cmd_op == FAULT_RELEASE);

  assign prog_part = prog_addr_i[4:2];
  assign prog_word = prog_addr_i[1:0];

  // ----------------------------------------
  // Fault injection
  // ----------------------------------------

  // Only the first injection is passed on, the next ones wait for a release
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_active_q <= 1'b0;
      inject_q       <= 1'b0;
      release_q      <= 1'b0;
    end else begin
      inject_q  <= 1'b0;
      release_q <= 1'b0;
      if (fault_cmd && !fault_active_q) begin
        inject_q       <= 1'b1;
        fault_active_q <= 1'b1;
      end else if (release_cmd) begin
        release_q      <= 1'b1;
        fault_active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fault_cmd) begin
      inject_kind_q <= (cmd_op == FAULT_CORR) ? CORRECTABLE : UNCORRECTABLE;
    end
  end

  // Writes go straight to the addressed slice, fault strobes go to all
  for (genvar i = 0; i < `OTP_NUM_PART; i++) begin : g_part_ctrl
    assign part_o[i].prog_we       = prog_we_i && (prog_part == otp_part_idx_t'(i));
    assign part_o[i].prog_word     = prog_word;
    assign part_o[i].prog_data     = prog_data_i;
    assign part_o[i].inject        = inject_q;
    assign part_o[i].inject_kind   = inject_kind_q;
    assign part_o[i].fault_release = release_q;
  end

  // ----------------------------------------
  // Life-cycle reset, clock and escalation
  // ----------------------------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst_active_q <= 1'b0;
      rst_cnt_q    <= '0;
    end else if (cmd_valid_i && cmd_op == LC_RESET && !rst_active_q) begin
      rst_active_q <= 1'b1;
      rst_cnt_q    <= '0;
    end else if (rst_active_q) begin
      if (rst_cnt_q == 4'(`OTP_RST_HOLD)) begin
        rst_active_q <= 1'b0;
        rst_cnt_q    <= '0;
      end else begin
        rst_cnt_q <= rst_cnt_q + 4'd1;
      end
    end
  end

  // A new selection wins over the clear of an acknowledged request
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_q     <= CLK_RST_MHZ;
      ext_clk_req_q <= 1'b0;
      esc_q         <= '0;
    end else begin
      if (clk_switch_o) begin
        ext_clk_req_q <= 1'b0;
      end
      if (cmd_valid_i && cmd_op == CLK_SEL) begin
        clk_sel_q     <= cmd_i.clk_view.mhz;
        ext_clk_req_q <= 1'b1;
      end
      if (cmd_valid_i && cmd_op == ESC_SET) begin
        esc_q[cmd_i.esc_view.esc_line] <= 1'b1;
      end else if (cmd_valid_i && cmd_op == ESC_CLR) begin
        esc_q[cmd_i.esc_view.esc_line] <= 1'b0;
      end
    end
  end

  assign lc_rst_b_o    = !rst_active_q;
  assign clk_sel_o     = clk_sel_q;
  assign ext_clk_req_o = ext_clk_req_q;
  assign clk_switch_o  = clk_byp_ack_i & ext_clk_req_q;
  assign esc_o         = esc_q;

  // Once the life-cycle reset drops it comes back exactly 11 cycles later
  lc_rst_hold_a: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    $fell(lc_rst_b_o) |-> ##11 lc_rst_b_o
  );

endmodule

// ==== hw/otp_part_slice.sv ====
// ----------------------------------------
// OTP partition slice
// Four-word storage with digest lock and
// a fault overlay on word 0
// ----------------------------------------

`timescale 1ns/10ps

`include "otp_svc_macros.svh"

module otp_part_slice (
  input  logic                        clk,
  input  logic                        cptra_rst_b,
  otp_part_if.part                    part_i,
  input  otp_part_pkg::otp_word_idx_t rd_word_i,
  output logic [`OTP_WORD_W-1:0]      rd_data_o,
  output logic                        locked_o,
  output logic                        faulted_o
);
  import otp_part_pkg::*;

  localparam otp_word_idx_t DIGEST_IDX = otp_word_idx_t'(`OTP_PART_WORDS - 1);

  // Data words below the digest
  logic [`OTP_WORD_W-1:0] data_mem [`OTP_PART_WORDS-1];
  logic [`OTP_WORD_W-1:0] digest_q;
  logic                   fault_q;
  logic [`OTP_WORD_W-1:0] fault_word_q;
  logic [`OTP_WORD_W-1:0] stored_word;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (part_i.prog_we && part_i.prog_word != DIGEST_IDX) begin
      data_mem[part_i.prog_word] <= part_i.prog_data;
    end
  end

  // The digest decides the lock, so it starts out cleared
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      digest_q <= '0;
    end else if (part_i.prog_we && part_i.prog_word == DIGEST_IDX) begin
      digest_q <= part_i.prog_data;
    end
  end

  assign locked_o = |digest_q;

  // ----------------------------------------
  // Fault overlay
  // ----------------------------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_q <= 1'b0;
    end else if (part_i.fault_release) begin
      fault_q <= 1'b0;
    end else if (part_i.inject && locked_o) begin
      fault_q <= 1'b1;
    end
  end

  // Correctable flips one bit, uncorrectable corrupts the whole word
  always_ff @(posedge clk) begin
    if (part_i.inject && locked_o) begin
      if (part_i.inject_kind == CORRECTABLE) begin
        fault_word_q <= data_mem[0] ^ `OTP_WORD_W'(1);
      end else begin
        fault_word_q <= ~data_mem[0];
      end
    end
  end

  assign faulted_o = fault_q;

  always_comb begin
    if (rd_word_i == DIGEST_IDX) begin
      stored_word = digest_q;
    end else begin
      stored_word = data_mem[rd_word_i];
    end
  end

  assign rd_data_o = (fault_q && rd_word_i == '0) ? fault_word_q : stored_word;

  // The decoder keeps the two fault strobes apart
  inject_release_excl_a: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    !(part_i.inject && part_i.fault_release)
  );

endmodule

// ==== hw/otp_read_mux.sv ====
// ----------------------------------------
// OTP read selection
// Registered word select across slices
// and the lock and fault maps
// ----------------------------------------

`timescale 1ns/10ps

`include "otp_svc_macros.svh"

module otp_read_mux (
  input  logic                        clk,
  input  logic                        cptra_rst_b,
  input  otp_part_pkg::otp_part_idx_t rd_part_i,
  input  logic [`OTP_WORD_W-1:0]      word_data_i [`OTP_NUM_PART],
  input  logic [`OTP_NUM_PART-1:0]    locked_i,
  input  logic [`OTP_NUM_PART-1:0]    faulted_i,
  output logic [`OTP_WORD_W-1:0]      rd_data_o,
  output logic [`OTP_NUM_PART-1:0]    locked_map_o,
  output logic [`OTP_NUM_PART-1:0]    fault_map_o
);
  import otp_part_pkg::*;

  logic [`OTP_WORD_W-1:0] sel_data;

  // Out-of-range partitions read as zero
  always_comb begin
    sel_data = '0;
    if (rd_part_i < otp_part_idx_t'(`OTP_NUM_PART)) begin
      sel_data = word_data_i[rd_part_i];
    end
  end

  always_ff @(posedge clk) begin
    rd_data_o <= sel_data;
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      locked_map_o <= '0;
      fault_map_o  <= '0;
    end else begin
      locked_map_o <= locked_i;
      fault_map_o  <= faulted_i;
    end
  end

  // Callers only ever address partitions that exist
  rd_part_range_a: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    rd_part_i < otp_part_idx_t'(`OTP_NUM_PART)
  );

endmodule

// ==== hw/otp_svc_top.sv ====
// ----------------------------------------
// OTP fault-injection and life-cycle
// service block, top level
// ----------------------------------------

`timescale 1ns/10ps

`include "otp_svc_macros.svh"

module otp_svc_top (
  input  logic                     clk,
  input  logic                     cptra_rst_b,
  input  logic                     cmd_valid_i,
  input  logic [15:0]              cmd_i,
  input  logic                     prog_we_i,
  input  logic [4:0]               prog_addr_i,
  input  logic [`OTP_WORD_W-1:0]   prog_data_i,
  input  logic [4:0]               rd_addr_i,
  input  logic                     clk_byp_ack_i,
  output logic [`OTP_WORD_W-1:0]   rd_data_o,
  output logic [`OTP_NUM_PART-1:0] locked_map_o,
  output logic [`OTP_NUM_PART-1:0] fault_map_o,
  output logic                     lc_rst_b_o,
  output logic [11:0]              clk_sel_o,
  output logic                     ext_clk_req_o,
  output logic                     clk_switch_o,
  output logic [1:0]               esc_o
);
  import otp_part_pkg::*;

  otp_part_idx_t          rd_part;
  otp_word_idx_t          rd_word;
  logic [`OTP_WORD_W-1:0] word_data [`OTP_NUM_PART];
  logic [`OTP_NUM_PART-1:0] locked;
  logic [`OTP_NUM_PART-1:0] faulted;

  otp_part_if part_if [`OTP_NUM_PART] ();

  // Upper address bits pick the partition, lower bits the word
  assign rd_part = rd_addr_i[4:2];
  assign rd_word = rd_addr_i[1:0];

  otp_svc_decoder u_decoder (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .prog_we_i     (prog_we_i),
    .prog_addr_i   (prog_addr_i),
    .prog_data_i   (prog_data_i),
    .clk_byp_ack_i (clk_byp_ack_i),
    .lc_rst_b_o    (lc_rst_b_o),
    .clk_sel_o     (clk_sel_o),
    .ext_clk_req_o (ext_clk_req_o),
    .clk_switch_o  (clk_switch_o),
    .esc_o         (esc_o),
    .part_o        (part_if)
  );

  for (genvar g = 0; g < `OTP_NUM_PART; g++) begin : g_slice
    otp_part_slice u_slice (
      .clk         (clk),
      .cptra_rst_b (cptra_rst_b),
      .part_i      (part_if[g]),
      .rd_word_i   (rd_word),
      .rd_data_o   (word_data[g]),
      .locked_o    (locked[g]),
      .faulted_o   (faulted[g])
    );
  end

  otp_read_mux u_read_mux (
    .clk          (clk),
    .cptra_rst_b  (cptra_rst_b),
    .rd_part_i    (rd_part),
    .word_data_i  (word_data),
    .locked_i     (locked),
    .faulted_i    (faulted),
    .rd_data_o    (rd_data_o),
    .locked_map_o (locked_map_o),
    .fault_map_o  (fault_map_o)
  );

endmodule

// ==== verif/otp_svc_tb.sv ====
// ----------------------------------------
// OTP service block testbench
// Table-driven commands checked against a
// shadow model of the fuse array
// ----------------------------------------

`timescale 1ns/10ps

`include "otp_svc_macros.svh"

module otp_svc_tb;
  import otp_cmd_pkg::*;

  typedef enum logic [1:0] {K_ARRAY, K_RST, K_CLK, K_ESC} chk_e;

  typedef struct {
    otp_opcode_e op;
    logic [11:0] arg;
    chk_e        kind;
  } entry_t;

  localparam int NUM_ENTRIES = 12;
  localparam int TIMEOUT     = NUM_ENTRIES * 20 + 200;

  logic clk;
  logic cptra_rst_b;
  logic cmd_valid_i;
  logic [15:0] cmd_i;
  logic prog_we_i;
  logic [4:0] prog_addr_i;
  logic [`OTP_WORD_W-1:0] prog_data_i;
  logic [4:0] rd_addr_i;
  logic clk_byp_ack_i;
  logic [`OTP_WORD_W-1:0] rd_data_o;
  logic [`OTP_NUM_PART-1:0] locked_map_o;
  logic [`OTP_NUM_PART-1:0] fault_map_o;
  logic lc_rst_b_o;
  logic [11:0] clk_sel_o;
  logic ext_clk_req_o;
  logic clk_switch_o;
  logic [1:0] esc_o;

  // Reference model state
  logic [`OTP_WORD_W-1:0] shadow [`OTP_NUM_PART][`OTP_PART_WORDS];
  logic fault_on;
  logic fault_uncorr;
  logic [11:0] clk_exp;
  logic [1:0] esc_exp;

  entry_t tbl [NUM_ENTRIES];
  logic [15:0] lfsr;
  int errors;
  int cycles;
  int p;
  int w;
  int e;
  int i;
  int low_cnt;
  logic [15:0] word;

  otp_svc_top u_dut (.*);

  always #50 clk = ~clk;

  // ----------------------------------------
  // Timeout
  // ----------------------------------------
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Errors: %0d", errors);
      $display("Test failed");
      $finish;
    end
  end

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit of the word
  task automatic rand_word(output logic [15:0] r);
    r = '0;
    for (int b = 0; b < 16; b++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[14:0], lfsr[0]};
    end
  endtask

  function automatic logic [`OTP_NUM_PART-1:0] exp_lock_map();
    logic [`OTP_NUM_PART-1:0] m;
    for (int k = 0; k < `OTP_NUM_PART; k++) begin
      m[k] = |shadow[k][`OTP_PART_WORDS-1];
    end
    return m;
  endfunction

  // Word 0 of a locked partition carries the fault while one is active
  function automatic logic [15:0] exp_read(input logic [4:0] addr);
    logic [15:0] v;
    v = shadow[addr[4:2]][addr[1:0]];
    if (fault_on && addr[1:0] == 2'd0 && |shadow[addr[4:2]][`OTP_PART_WORDS-1]) begin
      v = fault_uncorr ? ~v : v ^ 16'h0001;
    end
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      errors++;
      $display("Error: %s expected 0x%h got 0x%h", name, exp, got);
    end
  endtask

  task automatic update_model(input otp_opcode_e op, input logic [11:0] arg);
    case (op)
      FAULT_CORR, FAULT_UNCORR: begin
        if (!fault_on) begin
          fault_on = 1'b1;
          fault_uncorr = (op == FAULT_UNCORR);
        end
      end
      FAULT_RELEASE: fault_on = 1'b0;
      CLK_SEL:       clk_exp = arg;
      ESC_SET:       esc_exp[arg[0]] = 1'b1;
      ESC_CLR:       esc_exp[arg[0]] = 1'b0;
      default: ;
    endcase
  endtask

  // Address set on one falling edge is checked on the next
  task automatic read_all();
    for (int a = 0; a < `OTP_NUM_PART * `OTP_PART_WORDS; a++) begin
      rd_addr_i = 5'(a);
      @(negedge clk);
      check_val($sformatf("rd_data_o[%0d]", a), 32'(exp_read(5'(a))), 32'(rd_data_o));
    end
    check_val("locked_map_o", 32'(exp_lock_map()), 32'(locked_map_o));
    check_val("fault_map_o", 32'(fault_on ? exp_lock_map() : '0), 32'(fault_map_o));
  endtask

  task automatic load_table();
    tbl[0]  = '{NOP,           12'd0,   K_ARRAY};
    tbl[1]  = '{FAULT_CORR,    12'd0,   K_ARRAY};
    tbl[2]  = '{FAULT_UNCORR,  12'd0,   K_ARRAY};
    tbl[3]  = '{FAULT_RELEASE, 12'd0,   K_ARRAY};
    tbl[4]  = '{FAULT_UNCORR,  12'd0,   K_ARRAY};
    tbl[5]  = '{FAULT_RELEASE, 12'd0,   K_ARRAY};
    tbl[6]  = '{LC_RESET,      12'd0,   K_RST};
    tbl[7]  = '{CLK_SEL,       12'd500, K_CLK};
    tbl[8]  = '{CLK_SEL,       12'd160, K_CLK};
    tbl[9]  = '{ESC_SET,       12'd0,   K_ESC};
    tbl[10] = '{ESC_SET,       12'd1,   K_ESC};
    tbl[11] = '{ESC_CLR,       12'd0,   K_ESC};
  endtask

  initial begin
    clk = 1'b0;
    cptra_rst_b = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    prog_we_i = 1'b0;
    prog_addr_i = '0;
    prog_data_i = '0;
    rd_addr_i = '0;
    clk_byp_ack_i = 1'b0;
    errors = 0;
    cycles = 0;
    lfsr = 16'd44768;
    fault_on = 1'b0;
    fault_uncorr = 1'b0;
    clk_exp = 12'd1000;
    esc_exp = '0;
    load_table();

    repeat (3) @(negedge clk);
    cptra_rst_b = 1'b1;
    @(negedge clk);
    check_val("lc_rst_b_o", 32'd1, 32'(lc_rst_b_o));
    check_val("clk_sel_o", 32'd1000, 32'(clk_sel_o));
    check_val("ext_clk_req_o", 32'd0, 32'(ext_clk_req_o));
    check_val("clk_switch_o", 32'd0, 32'(clk_switch_o));
    check_val("esc_o", 32'd0, 32'(esc_o));
    check_val("fault_map_o", 32'd0, 32'(fault_map_o));

    // Partitions 0, 2 and 5 get a non-zero digest and lock
    for (p = 0; p < `OTP_NUM_PART; p++) begin
      for (w = 0; w < `OTP_PART_WORDS; w++) begin
        rand_word(word);
        if (w == `OTP_PART_WORDS - 1) begin
          if (p == 0 || p == 2 || p == 5) begin
            word = (word == '0) ? 16'h0001 : word;
          end else begin
            word = '0;
          end
        end
        shadow[p][w] = word;
        @(negedge clk);
        prog_we_i = 1'b1;
        prog_addr_i = {3'(p), 2'(w)};
        prog_data_i = word;
      end
    end
    @(negedge clk);
    prog_we_i = 1'b0;

    for (e = 0; e < NUM_ENTRIES; e++) begin
      @(negedge clk);
      cmd_valid_i = 1'b1;
      cmd_i = {tbl[e].op, tbl[e].arg};
      update_model(tbl[e].op, tbl[e].arg);
      @(negedge clk);
      cmd_valid_i = 1'b0;
      case (tbl[e].kind)
        K_ARRAY: begin
          // The fault strobe is registered and the overlay updates a cycle later
          @(negedge clk);
          read_all();
        end
        K_RST: begin
          // The hold begins in the cycle right after the command
          check_val("lc_rst_b_o", 32'd0, 32'(lc_rst_b_o));
          low_cnt = 0;
          i = 0;
          while (i < 20 && !(lc_rst_b_o && low_cnt > 0)) begin
            if (!lc_rst_b_o) begin
              low_cnt++;
            end
            cmd_valid_i = (i == 3);
            cmd_i = {LC_RESET, 12'd0};
            @(negedge clk);
            i++;
          end
          cmd_valid_i = 1'b0;
          check_val("lc_rst_b_o low cycles", 32'd11, 32'(low_cnt));
        end
        K_CLK: begin
          check_val("clk_sel_o", 32'(clk_exp), 32'(clk_sel_o));
          check_val("ext_clk_req_o", 32'd1, 32'(ext_clk_req_o));
          check_val("clk_switch_o", 32'd0, 32'(clk_switch_o));
          clk_byp_ack_i = 1'b1;
          #1;
          check_val("clk_switch_o", 32'd1, 32'(clk_switch_o));
          @(negedge clk);
          check_val("ext_clk_req_o", 32'd0, 32'(ext_clk_req_o));
          check_val("clk_switch_o", 32'd0, 32'(clk_switch_o));
          clk_byp_ack_i = 1'b0;
        end
        default: begin
          check_val("esc_o", 32'(esc_exp), 32'(esc_o));
        end
      endcase
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/otp_cmd_pkg.sv
hw/otp_part_pkg.sv
hw/otp_part_if.sv
hw/otp_svc_decoder.sv
hw/otp_part_slice.sv
hw/otp_read_mux.sv
hw/otp_svc_top.sv
verif/otp_svc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the OTP service block simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module otp_svc_tb -o otp_svc_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/otp_svc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
